/* hw/feature_fetcher.sv */
`timescale 1ns/1ps
`default_nettype none
`include "octree_cfg.svh"

module feature_fetcher
  import octree_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   start_i,
  input  wire logic   anchor_push_i,
  input  wire level_t anchor_level_i,
  input  wire pos_t   anchor_pos_i,
  output logic        anchor_full_o,
  input  wire logic   walk_done_i,
  output logic        req_o,
  output addr_t       addr_o,
  input  wire logic   gnt_i,
  input  wire logic   rvalid_i,
  input  wire word_t  rdata_i,
  output word_t       feature_o,
  output logic        feature_valid_o,
  input  wire logic   feature_ready_i,
  output logic        busy_o,
  output logic        done_o
);

  localparam int ENTRY_BITS = `LEVEL_BITS + `POS_BITS;
  localparam int WCNT_BITS  = (`FEATURE_LEN > 1) ? $clog2(`FEATURE_LEN) : 1;

  fetch_state_e                  state;
  logic [`FEATURE_SLOT_BITS-1:0] fslot;
  logic [WCNT_BITS-1:0]          word_cnt;
  word_t                         feature_q;
  logic                          busy_q;
  logic                          walk_seen;

  logic [ENTRY_BITS-1:0] aq_din;
  logic [ENTRY_BITS-1:0] aq_dout;
  logic                  aq_pop;
  logic                  aq_empty;
  level_t                head_level;
  pos_t                  head_pos;
  slot_t                 head_slot;
  logic                  last_word;

  assign aq_din                 = {anchor_level_i, anchor_pos_i};
  assign {head_level, head_pos} = aq_dout;
  assign head_slot              = level_base(head_level) + slot_t'(head_pos);
  assign aq_pop                 = (state == FETCH_IDLE) && !aq_empty;
  assign last_word              = (word_cnt == WCNT_BITS'(`FEATURE_LEN - 1));

  assign req_o  = (state == FETCH_READ);
  assign addr_o = addr_t'(`FEATURE_BASE) + addr_t'(fslot) * addr_t'(`FEATURE_LEN) +
                  addr_t'(word_cnt);

  assign feature_valid_o = (state == FETCH_HOLD);
  assign feature_o       = feature_q;
  // walk finished, queue drained, last word taken
  assign done_o = busy_q && walk_seen && aq_empty && (state == FETCH_IDLE);
  assign busy_o = busy_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= FETCH_IDLE;
      word_cnt  <= '0;
      busy_q    <= 1'b0;
      walk_seen <= 1'b0;
    end else begin
      case (state)
        FETCH_IDLE: begin
          if (!aq_empty) begin
            word_cnt <= '0;
            state    <= FETCH_READ;
          end
        end
        FETCH_READ: begin
          if (gnt_i) begin
            state <= FETCH_WAIT;
          end
        end
        FETCH_WAIT: begin
          if (rvalid_i) begin
            state <= FETCH_HOLD;
          end
        end
        FETCH_HOLD: begin
          if (feature_ready_i) begin
            word_cnt <= word_cnt + WCNT_BITS'(1);
            state    <= last_word ? FETCH_IDLE : FETCH_READ;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
      if (start_i && !busy_q) begin
        busy_q    <= 1'b1;
        walk_seen <= 1'b0;
      end else if (done_o) begin
        busy_q <= 1'b0;
      end
      if (walk_done_i) begin
        walk_seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aq_pop) begin
      fslot <= head_slot[`FEATURE_SLOT_BITS-1:0];
    end
    if ((state == FETCH_WAIT) && rvalid_i) begin
      feature_q <= rdata_i;
    end
  end

  sync_fifo #(
    .WIDTH (ENTRY_BITS),
    .DEPTH (`ANCHOR_DEPTH)
  ) u_anchor_q (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (anchor_push_i),
    .data_i  (aq_din),
    .pop_i   (aq_pop),
    .data_o  (aq_dout),
    .empty_o (aq_empty),
    .full_o  (anchor_full_o)
  );

endmodule

`default_nettype wire

/* hw/octree_cfg.svh */
`ifndef OCTREE_CFG_SVH
`define OCTREE_CFG_SVH

// tree shape
`define TREE_LEVELS 4
`define LEVEL_BITS 3
`define POS_BITS 12
`define SLOT_BITS 12

// sram geometry
`define ADDR_BITS 16
`define WORD_BITS 64
`define NODE_BASE 0

// feature region, words per anchor
`define FEATURE_BASE 1024
`define FEATURE_LEN 4
`define FEATURE_SLOT_BITS 8

// queue sizes
`define SEARCH_DEPTH 64
`define ANCHOR_DEPTH 16

`endif

/* hw/octree_pkg.sv */
`default_nettype none
`include "octree_cfg.svh"

package octree_pkg;

  typedef logic [`ADDR_BITS-1:0]   addr_t;
  typedef logic [`WORD_BITS-1:0]   word_t;
  typedef logic [`LEVEL_BITS-1:0]  level_t;
  typedef logic [`POS_BITS-1:0]    pos_t;
  typedef logic [`SLOT_BITS-1:0]   slot_t;
  typedef logic [`TREE_LEVELS-1:0] lod_mask_t;

  typedef enum logic [1:0] {WALK_IDLE, WALK_POP, WALK_READ, WALK_SCAN} walk_state_e;
  typedef enum logic [1:0] {FETCH_IDLE, FETCH_READ, FETCH_WAIT, FETCH_HOLD} fetch_state_e;

  // slots in all shallower levels: 0, 1, 9, 73, 585
  function automatic slot_t level_base(input level_t lvl);
    slot_t base;
    base = '0;
    for (int k = 0; k < `TREE_LEVELS; k++) begin
      if (k < int'(lvl)) begin
        base = base + (slot_t'(1) << (3 * k));
      end
    end
    return base;
  endfunction

endpackage

`default_nettype wire

/* hw/octree_searcher.sv */
`timescale 1ns/1ps
`default_nettype none

module octree_searcher
  import octree_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      start_i,
  input  wire lod_mask_t lod_mask_i,
  output logic           busy_o,
  output logic           done_o,
  output logic           sram_cen_o,
  output addr_t          sram_addr_o,
  input  wire word_t     sram_q_i,
  output word_t          feature_o,
  output logic           feature_valid_o,
  input  wire logic      feature_ready_i
);

  logic   start_go;
  logic   walk_req;
  addr_t  walk_addr;
  logic   walk_gnt;
  logic   walk_rvalid;
  word_t  walk_rdata;
  logic   fetch_req;
  addr_t  fetch_addr;
  logic   fetch_gnt;
  logic   fetch_rvalid;
  word_t  fetch_rdata;
  logic   anchor_push;
  level_t anchor_level;
  pos_t   anchor_pos;
  logic   anchor_full;
  logic   walk_done;

  // starts during a search are dropped
  assign start_go = start_i && !busy_o;

  tree_walker u_walker (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (start_go),
    .lod_mask_i     (lod_mask_i),
    .req_o          (walk_req),
    .addr_o         (walk_addr),
    .gnt_i          (walk_gnt),
    .rvalid_i       (walk_rvalid),
    .rdata_i        (walk_rdata),
    .anchor_push_o  (anchor_push),
    .anchor_level_o (anchor_level),
    .anchor_pos_o   (anchor_pos),
    .anchor_full_i  (anchor_full),
    .walk_done_o    (walk_done)
  );

  feature_fetcher u_fetcher (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start_go),
    .anchor_push_i   (anchor_push),
    .anchor_level_i  (anchor_level),
    .anchor_pos_i    (anchor_pos),
    .anchor_full_o   (anchor_full),
    .walk_done_i     (walk_done),
    .req_o           (fetch_req),
    .addr_o          (fetch_addr),
    .gnt_i           (fetch_gnt),
    .rvalid_i        (fetch_rvalid),
    .rdata_i         (fetch_rdata),
    .feature_o       (feature_o),
    .feature_valid_o (feature_valid_o),
    .feature_ready_i (feature_ready_i),
    .busy_o          (busy_o),
    .done_o          (done_o)
  );

  sram_arbiter u_arbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .walk_req_i     (walk_req),
    .walk_addr_i    (walk_addr),
    .walk_gnt_o     (walk_gnt),
    .walk_rvalid_o  (walk_rvalid),
    .walk_rdata_o   (walk_rdata),
    .fetch_req_i    (fetch_req),
    .fetch_addr_i   (fetch_addr),
    .fetch_gnt_o    (fetch_gnt),
    .fetch_rvalid_o (fetch_rvalid),
    .fetch_rdata_o  (fetch_rdata),
    .sram_cen_o     (sram_cen_o),
    .sram_addr_o    (sram_addr_o),
    .sram_q_i       (sram_q_i)
  );

endmodule

`default_nettype wire

/* hw/sram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter
  import octree_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  walk_req_i,
  input  wire addr_t walk_addr_i,
  output logic       walk_gnt_o,
  output logic       walk_rvalid_o,
  output word_t      walk_rdata_o,
  input  wire logic  fetch_req_i,
  input  wire addr_t fetch_addr_i,
  output logic       fetch_gnt_o,
  output logic       fetch_rvalid_o,
  output word_t      fetch_rdata_o,
  output logic       sram_cen_o,
  output addr_t      sram_addr_o,
  input  wire word_t sram_q_i
);

  logic walk_pend;
  logic fetch_pend;

  // walker has priority
  assign walk_gnt_o  = walk_req_i;
  assign fetch_gnt_o = fetch_req_i && !walk_req_i;
  assign sram_cen_o  = !(walk_req_i || fetch_req_i);
  assign sram_addr_o = walk_req_i ? walk_addr_i : fetch_addr_i;

  // read data lands one cycle after the grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      walk_pend  <= 1'b0;
      fetch_pend <= 1'b0;
    end else begin
      walk_pend  <= walk_gnt_o;
      fetch_pend <= fetch_gnt_o;
    end
  end

  assign walk_rvalid_o  = walk_pend;
  assign fetch_rvalid_o = fetch_pend;
  assign walk_rdata_o   = sram_q_i;
  assign fetch_rdata_o  = sram_q_i;

endmodule

`default_nettype wire

/* hw/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             push_i,
  input  wire logic [WIDTH-1:0] data_i,
  input  wire logic             pop_i,
  output logic      [WIDTH-1:0] data_o,
  output logic                  empty_o,
  output logic                  full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_W'(DEPTH));
  // head shows without a read cycle
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      if (do_push && !do_pop) begin
        count <= count + CNT_W'(1);
      end else if (do_pop && !do_push) begin
        count <= count - CNT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* hw/tree_walker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "octree_cfg.svh"

module tree_walker
  import octree_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      start_i,
  input  wire lod_mask_t lod_mask_i,
  output logic           req_o,
  output addr_t          addr_o,
  input  wire logic      gnt_i,
  input  wire logic      rvalid_i,
  input  wire word_t     rdata_i,
  output logic           anchor_push_o,
  output level_t         anchor_level_o,
  output pos_t           anchor_pos_o,
  input  wire logic      anchor_full_i,
  output logic           walk_done_o
);

  localparam int ENTRY_BITS = `LEVEL_BITS + `POS_BITS;

  walk_state_e state;
  level_t      cur_level;
  pos_t        cur_pos;
  logic [7:0]  child_bits;
  logic [7:0]  self_bits;
  logic [2:0]  oct;
  logic        rd_pending;

  slot_t       node_slot;
  level_t      child_level;
  pos_t        child_pos;
  logic [15:0] lane_bits;
  logic        stall;
  logic        root_push;
  logic        child_push;

  logic                  sq_push;
  logic [ENTRY_BITS-1:0] sq_din;
  logic                  sq_pop;
  logic [ENTRY_BITS-1:0] sq_dout;
  logic                  sq_empty;
  logic                  sq_full;

  assign node_slot   = level_base(cur_level) + slot_t'(cur_pos);
  assign child_level = cur_level + level_t'(1);
  // child position is 8*p + octant
  assign child_pos   = {cur_pos[`POS_BITS-4:0], oct};
  // four 16-bit lanes per word
  assign lane_bits   = rdata_i[{node_slot[1:0], 4'b0000} +: 16];

  assign stall      = anchor_full_i || sq_full;
  assign root_push  = (state == WALK_IDLE) && start_i;
  assign child_push = (state == WALK_SCAN) && !stall && child_bits[oct] &&
                      (child_level < level_t'(`TREE_LEVELS));

  assign anchor_push_o  = (state == WALK_SCAN) && !stall && self_bits[oct] &&
                          lod_mask_i[cur_level[1:0]];
  assign anchor_level_o = child_level;
  assign anchor_pos_o   = child_pos;

  assign sq_push = root_push || child_push;
  assign sq_din  = root_push ? '0 : {child_level, child_pos};
  assign sq_pop  = (state == WALK_POP) && !sq_empty;

  assign req_o       = (state == WALK_READ) && !rd_pending;
  assign addr_o      = addr_t'(`NODE_BASE) + addr_t'(node_slot[`SLOT_BITS-1:2]);
  assign walk_done_o = (state == WALK_POP) && sq_empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= WALK_IDLE;
      oct        <= '0;
      rd_pending <= 1'b0;
    end else begin
      case (state)
        WALK_IDLE: begin
          if (start_i) begin
            state <= WALK_POP;
          end
        end
        WALK_POP: begin
          state <= sq_empty ? WALK_IDLE : WALK_READ;
        end
        WALK_READ: begin
          if (gnt_i) begin
            rd_pending <= 1'b1;
          end
          if (rvalid_i) begin
            rd_pending <= 1'b0;
            oct        <= '0;
            state      <= WALK_SCAN;
          end
        end
        WALK_SCAN: begin
          // one octant per cycle
          if (!stall) begin
            oct <= oct + 3'd1;
            if (oct == 3'd7) begin
              state <= WALK_POP;
            end
          end
        end
        default: state <= WALK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sq_pop) begin
      {cur_level, cur_pos} <= sq_dout;
    end
    if ((state == WALK_READ) && rvalid_i) begin
      for (int i = 0; i < 8; i++) begin
        child_bits[i] <= lane_bits[2*i];
        self_bits[i]  <= lane_bits[2*i+1];
      end
    end
  end

  // search queue of level and position
  sync_fifo #(
    .WIDTH (ENTRY_BITS),
    .DEPTH (`SEARCH_DEPTH)
  ) u_search_q (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (sq_push),
    .data_i  (sq_din),
    .pop_i   (sq_pop),
    .data_o  (sq_dout),
    .empty_o (sq_empty),
    .full_o  (sq_full)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_octree_searcher -o sim_octree

# the log decides the result, tee keeps the pipeline status at zero
./obj_dir/sim_octree | tee sim.log

if grep -q "Done: no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* sim/sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_model
  import octree_pkg::*;
#(
  parameter int DEPTH = 2048
) (
  input  wire logic  clk,
  input  wire logic  cen_i,
  input  wire addr_t addr_i,
  output word_t      q_o
);

  localparam int AW = $clog2(DEPTH);

  // loaded by the testbench through hierarchical writes
  word_t mem [DEPTH];

  initial begin
    // pattern on untouched words, unique per address
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = {16'hdead, 16'(a), 16'(~a), 16'(a)};
    end
  end

  // one cycle read latency, chip enable active low
  always_ff @(posedge clk) begin
    if (!cen_i) begin
      q_o <= mem[addr_i[AW-1:0]];
    end
  end

endmodule

`default_nettype wire

/* sim/tb_octree_searcher.sv */
`timescale 1ns/1ps
`default_nettype none
`include "octree_cfg.svh"

module tb_octree_searcher
  import octree_pkg::*;
();

  // longest search is about 150 anchors at 17 cycles each under half-rate ready
  localparam int CYCLE_LIMIT = 20000;
  localparam int MEM_WORDS   = 2048;
  // the fixed tree walk ends well inside this many cycles
  localparam int WALK_HOLD   = 200;

  logic      clk;
  logic      rst_n;
  logic      start_i;
  lod_mask_t lod_mask_i;
  logic      busy_o;
  logic      done_o;
  logic      sram_cen_o;
  addr_t     sram_addr_o;
  word_t     sram_q_i;
  word_t     feature_o;
  logic      feature_valid_o;
  logic      feature_ready_i;

  word_t       image [MEM_WORDS];
  word_t       expected_q [$];
  logic [15:0] lfsr;
  logic        rand_ready;
  int          cycles = 0;
  int          done_count = 0;
  int          words_seen = 0;

  octree_searcher uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start_i),
    .lod_mask_i      (lod_mask_i),
    .busy_o          (busy_o),
    .done_o          (done_o),
    .sram_cen_o      (sram_cen_o),
    .sram_addr_o     (sram_addr_o),
    .sram_q_i        (sram_q_i),
    .feature_o       (feature_o),
    .feature_valid_o (feature_valid_o),
    .feature_ready_i (feature_ready_i)
  );

  sram_model #(
    .DEPTH (MEM_WORDS)
  ) u_sram (
    .clk    (clk),
    .cen_i  (sram_cen_o),
    .addr_i (sram_addr_o),
    .q_o    (sram_q_i)
  );

  always #20 clk = ~clk;

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    assert (actual === expected) else
      stop_with_error($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
  endtask

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic random_bit();
    lfsr = lfsr_next(lfsr);
    return lfsr[0];
  endfunction

  function automatic logic [7:0] random_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v[b] = random_bit();
    end
    return v;
  endfunction

  // slots in all levels above lvl
  function automatic int slot_base(input int lvl);
    int base;
    base = 0;
    for (int k = 0; k < lvl; k++) begin
      base = base + (1 << (3 * k));
    end
    return base;
  endfunction

  function automatic word_t feature_word(input int s, input int k);
    return {16'hfeed, 16'(s), 16'(k), 16'(s * 7 + k)};
  endfunction

  task automatic write_word(input int a, input word_t w);
    image[a] = w;
    u_sram.mem[a] = w;
  endtask

  task automatic clear_memory();
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (a < `FEATURE_BASE) begin
        write_word(a, '0);
      end else begin
        write_word(a, feature_word((a - `FEATURE_BASE) / `FEATURE_LEN,
                                   (a - `FEATURE_BASE) % `FEATURE_LEN));
      end
    end
  endtask

  task automatic set_node(input int lvl, input int pos, input logic [7:0] child,
                          input logic [7:0] self);
    int    slot;
    int    lane;
    word_t w;
    slot = slot_base(lvl) + pos;
    lane = slot % 4;
    w = image[`NODE_BASE + slot / 4];
    for (int i = 0; i < 8; i++) begin
      w[16 * lane + 2 * i]     = child[i];
      w[16 * lane + 2 * i + 1] = self[i];
    end
    write_word(`NODE_BASE + slot / 4, w);
  endtask

  task automatic build_fixed_tree();
    clear_memory();
    set_node(0, 0, 8'b1000_0101, 8'b0100_0010);
    set_node(1, 0, 8'b0001_0001, 8'b1000_0001);
    set_node(1, 2, 8'b0000_0000, 8'b0000_1100);
    set_node(1, 7, 8'b0010_0000, 8'b0000_0000);
    set_node(2, 0, 8'b0000_0010, 8'b0000_0001);
    set_node(2, 4, 8'b0000_0000, 8'b0000_0011);
    set_node(2, 61, 8'b1000_0000, 8'b0010_0000);
    // child bits on the last level must be ignored
    set_node(3, 1, 8'b1111_1111, 8'b0001_0010);
    set_node(3, 495, 8'b0000_0000, 8'b1000_0000);
  endtask

  task automatic build_random_tree();
    int         cur [$];
    int         nxt [$];
    logic [7:0] child;
    logic [7:0] self;
    int         p;
    clear_memory();
    cur.push_back(0);
    for (int lvl = 0; lvl < `TREE_LEVELS; lvl++) begin
      nxt.delete();
      foreach (cur[n]) begin
        p = cur[n];
        child = random_bits(8) | random_bits(8);
        self  = random_bits(8) & random_bits(8);
        if (lvl + 1 < `TREE_LEVELS) begin
          // at most 32 nodes per level
          for (int i = 0; i < 8; i++) begin
            if (child[i] && nxt.size() < 32) begin
              nxt.push_back(8 * p + i);
            end else begin
              child[i] = 1'b0;
            end
          end
        end
        set_node(lvl, p, child, self);
      end
      cur = nxt;
    end
  endtask

  // breadth-first walk of the image, appends the expected feature words
  function automatic void build_expected(input lod_mask_t mask);
    int          lvl_q [$];
    int          pos_q [$];
    int          lvl;
    int          pos;
    int          slot;
    int          fslot;
    logic [15:0] lane;
    lvl_q.push_back(0);
    pos_q.push_back(0);
    while (lvl_q.size() > 0) begin
      lvl  = lvl_q.pop_front();
      pos  = pos_q.pop_front();
      slot = slot_base(lvl) + pos;
      lane = image[`NODE_BASE + slot / 4][16 * (slot % 4) +: 16];
      for (int i = 0; i < 8; i++) begin
        if (lane[2 * i] && (lvl + 1 < `TREE_LEVELS)) begin
          lvl_q.push_back(lvl + 1);
          pos_q.push_back(8 * pos + i);
        end
        if (lane[2 * i + 1] && mask[lvl]) begin
          fslot = (slot_base(lvl + 1) + 8 * pos + i) % (1 << `FEATURE_SLOT_BITS);
          for (int k = 0; k < `FEATURE_LEN; k++) begin
            expected_q.push_back(feature_word(fslot, k));
          end
        end
      end
    end
  endfunction

  task automatic run_search(input lod_mask_t mask, input logic restart_while_busy);
    int start_done;
    int start_words;
    int want;
    start_done  = done_count;
    start_words = words_seen;
    build_expected(mask);
    want = expected_q.size();
    lod_mask_i = mask;
    start_i = 1'b1;
    @(posedge clk);
    #1;
    start_i = 1'b0;
    @(negedge clk);
    check_value("busy_o", 64'(busy_o), 64'd1);
    @(posedge clk);
    #1;
    if (restart_while_busy) begin
      // stalled stream keeps the search busy after the walker goes idle
      feature_ready_i = 1'b0;
      repeat (WALK_HOLD) @(posedge clk);
      #1;
      check_value("busy_o", 64'(busy_o), 64'd1);
      start_i = 1'b1;
      @(posedge clk);
      #1;
      start_i = 1'b0;
    end
    while (done_count == start_done) begin
      feature_ready_i = rand_ready ? random_bit() : 1'b1;
      @(posedge clk);
      #1;
    end
    feature_ready_i = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    assert (done_count == start_done + 1) else
      stop_with_error("done_o pulsed more than once for one search");
    check_value("busy_o", 64'(busy_o), 64'd0);
    assert (words_seen - start_words == want) else
      stop_with_error("the search gave the wrong number of feature words");
  endtask

  // sampled mid-cycle, a transfer happens at the next rising edge
  always @(negedge clk) begin
    word_t want_word;
    if (rst_n && feature_valid_o && feature_ready_i) begin
      assert (expected_q.size() != 0) else
        stop_with_error("a feature word arrived after all expected words");
      if (expected_q.size() != 0) begin
        want_word = expected_q.pop_front();
        check_value("feature_o", feature_o, want_word);
        words_seen++;
      end
    end
    if (rst_n && done_o) begin
      assert (expected_q.size() == 0) else
        stop_with_error("done_o came before all expected feature words arrived");
      done_count++;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    assert (cycles < CYCLE_LIMIT) else
      stop_with_error("timeout, the run went past the cycle limit");
  end

  initial begin
    logic [7:0] mask_bits;
    clk             = 1'b0;
    rst_n           = 1'b0;
    start_i         = 1'b0;
    lod_mask_i      = '0;
    feature_ready_i = 1'b1;
    rand_ready      = 1'b0;
    lfsr            = 16'd58;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("sram_cen_o", 64'(sram_cen_o), 64'd1);
    check_value("feature_valid_o", 64'(feature_valid_o), 64'd0);
    check_value("busy_o", 64'(busy_o), 64'd0);
    check_value("done_o", 64'(done_o), 64'd0);
    @(posedge clk);
    #1;

    build_fixed_tree();
    run_search(4'b1111, 1'b0);
    // levels 0 and 2 masked
    run_search(4'b1010, 1'b0);

    build_random_tree();
    mask_bits = random_bits(4);
    rand_ready = 1'b1;
    run_search(mask_bits[3:0] | 4'b1000, 1'b0);
    rand_ready = 1'b0;

    // empty root
    clear_memory();
    run_search(4'b1111, 1'b0);

    build_fixed_tree();
    run_search(4'b1111, 1'b1);
    build_random_tree();
    run_search(4'b1111, 1'b0);

    assert (expected_q.size() == 0) else
      stop_with_error("expected feature words were left over at the end");
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hw
hw/octree_pkg.sv
hw/sync_fifo.sv
hw/tree_walker.sv
hw/feature_fetcher.sv
hw/sram_arbiter.sv
hw/octree_searcher.sv
sim/sram_model.sv
sim/tb_octree_searcher.sv
